// ==== Makefile ====
SRCS := $(shell cat verilog.f)

.PHONY: run clean

run: obj_dir/Vobj_dma_tb
	out=$$(./obj_dir/Vobj_dma_tb); echo "$$out"; echo "$$out" | grep -q "All tests passed!"

obj_dir/Vobj_dma_tb: verilog.f $(SRCS)
	verilator --binary --timing --assert --top-module obj_dma_tb -f verilog.f

clean:
	rm -rf obj_dir

// ==== dv/obj_dma_tb.sv ====
// directed testbench for the object table subsystem and the top of the simulation
`timescale 1ns/100ps
`default_nettype none

module obj_dma_tb import obj_pkg::*;;

    localparam int lat_max = 4;
    localparam vram_base_t base_reg = 16'h0124;
    // table start in VRAM words taken from base bits 9 to 1
    localparam vram_addr_t base_word = {base_reg[9:1], 8'd0};

    logic        clk;
    logic        rst;
    logic        pxl_cen;
    logic        obj_dma_ok;
    vram_base_t  vram_base;
    logic        cpu_rd;
    vram_addr_t  cpu_addr;
    vram_word_t  mem_data;
    logic        mem_ok;
    table_addr_t table_addr;
    vram_addr_t  mem_addr;
    vram_word_t  cpu_data;
    logic        cpu_ok;
    vram_word_t  table_data;
    logic        busreq;

    logic [2:0]  lat;
    logic [31:0] lat_state;
    logic [33:0] lat_pair;
    logic [31:0] data_state;
    vram_word_t  vram_img [0:1023];
    vram_word_t  exp_tab [0:1023];
    vram_word_t  prev_tab [0:1023];

    obj_dma_sys obj_dma_sys_inst (
        .clk        (clk),
        .rst        (rst),
        .pxl_cen    (pxl_cen),
        .obj_dma_ok (obj_dma_ok),
        .vram_base  (vram_base),
        .cpu_rd     (cpu_rd),
        .cpu_addr   (cpu_addr),
        .mem_data   (mem_data),
        .mem_ok     (mem_ok),
        .table_addr (table_addr),
        .mem_addr   (mem_addr),
        .cpu_data   (cpu_data),
        .cpu_ok     (cpu_ok),
        .table_data (table_data),
        .busreq     (busreq)
    );

    vram_model #(.lat_max(lat_max)) vram_model_inst (
        .clk  (clk),
        .rst  (rst),
        .lat  (lat),
        .addr (mem_addr),
        .data (mem_data),
        .ok   (mem_ok)
    );

    always #5 clk = ~clk;

    // pixel enable every other cycle
    always @(posedge clk) pxl_cen <= ~pxl_cen;

    // galois LFSR whose output bit is the one shifted out
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    function automatic logic [33:0] take_two(input logic [31:0] s);
        logic [31:0] s1;
        s1 = lfsr_step(s);
        return {s1[0], s[0], lfsr_step(s1)};
    endfunction

    // fresh latency of 1 to 4 cycles every clock
    always @(posedge clk) begin
        lat_pair = take_two(lat_state);
        lat_state <= lat_pair[31:0];
        lat <= 3'(lat_pair[33:32]) + 3'd1;
    end

    task automatic next_word(output vram_word_t v);
        for (int i = 0; i < 16; i++) begin
            v[i] = data_state[0];
            data_state = lfsr_step(data_state);
        end
    endtask

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("error: %s expected %h actual %h", name, exp, act);
            fail_now("value mismatch");
        end
    endtask

    // random table with no end marker that is mirrored in vram_img
    task automatic load_table();
        vram_word_t v;
        for (int k = 0; k < 1024; k++) begin
            next_word(v);
            if (v[15:8] == end_marker) begin
                v[15:8] = 8'h7F;
            end
            vram_img[k] = v;
            vram_model_inst.load_word(base_word + 17'(k), v);
        end
    endtask

    task automatic place_marker(input int g);
        vram_img[4 * g + 3][15:8] = end_marker;
        vram_model_inst.load_word(base_word + 17'(4 * g + 3), vram_img[4 * g + 3]);
    endtask

    // copy up to the first group whose word 3 has the marker and zeros after it
    task automatic compute_expected();
        int end_g;
        end_g = 256;
        for (int g = 255; g >= 0; g--) begin
            if (vram_img[4 * g + 3][15:8] == end_marker) begin
                end_g = g;
            end
        end
        for (int a = 0; a < 1024; a++) begin
            exp_tab[a] = (a < 4 * end_g) ? vram_img[a] : 16'h0000;
        end
    endtask

    task automatic wait_busreq(input logic level, input int limit, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (busreq !== level) begin
            if (n >= limit) begin
                fail_now({"timeout waiting for busreq in ", what});
            end
            n++;
            @(negedge clk);
        end
    endtask

    task automatic pulse_dma_ok();
        @(posedge clk);
        obj_dma_ok <= 1'b1;
        @(posedge clk);
        obj_dma_ok <= 1'b0;
    endtask

    task automatic finish_dma(input string what);
        wait_busreq(1'b0, 50000, what);
        // room for the zero fill
        repeat (1100) @(posedge clk);
    endtask

    task automatic run_dma(input string what);
        pulse_dma_ok();
        wait_busreq(1'b1, 10, what);
        finish_dma(what);
    endtask

    task automatic read_entries(input string name, input int count, input logic use_prev);
        vram_word_t e;
        for (int a = 0; a < count; a++) begin
            @(posedge clk);
            table_addr <= 10'(a);
            @(posedge clk);
            @(negedge clk);
            e = use_prev ? prev_tab[a] : exp_tab[a];
            compare($sformatf("%s entry %0d", name, a), 32'(e), 32'(table_data));
        end
    endtask

    // a new frame swaps the finished table onto the read side
    task automatic show_and_check(input string name);
        pulse_dma_ok();
        read_entries(name, 1024, 1'b0);
        finish_dma(name);
    endtask

    task automatic cpu_read(input string name, input int k);
        int n;
        n = 0;
        @(posedge clk);
        cpu_addr <= base_word + 17'(k);
        cpu_rd   <= 1'b1;
        @(negedge clk);
        while (cpu_ok !== 1'b1) begin
            if (n >= 100) begin
                fail_now({"timeout waiting for cpu_ok in ", name});
            end
            n++;
            @(negedge clk);
        end
        compare(name, 32'(vram_img[k]), 32'(cpu_data));
        @(posedge clk);
        cpu_rd <= 1'b0;
    endtask

    task automatic test_reset();
        @(negedge clk);
        compare("reset busreq", 32'd0, 32'(busreq));
        compare("reset cpu_ok", 32'd0, 32'(cpu_ok));
        repeat (1100) @(posedge clk);
    endtask

    task automatic test_full_copy();
        load_table();
        compute_expected();
        run_dma("full_copy");
        show_and_check("full_copy");
    endtask

    task automatic test_end_marker();
        load_table();
        place_marker(37);
        compute_expected();
        run_dma("end_marker");
        show_and_check("end_marker");
    endtask

    task automatic test_double_buffer();
        load_table();
        compute_expected();
        run_dma("double_buffer first");
        prev_tab = exp_tab;
        load_table();
        compute_expected();
        pulse_dma_ok();
        // old frame stays visible while the copy runs
        read_entries("double_buffer busy", 64, 1'b1);
        compare("double_buffer busreq held", 32'd1, 32'(busreq));
        finish_dma("double_buffer second");
        show_and_check("double_buffer new");
    endtask

    task automatic test_restart();
        load_table();
        compute_expected();
        pulse_dma_ok();
        wait_busreq(1'b1, 10, "restart");
        repeat (300) @(negedge clk);
        compare("restart busreq mid copy", 32'd1, 32'(busreq));
        // new VRAM contents so any word kept from before the restart shows up
        load_table();
        compute_expected();
        pulse_dma_ok();
        finish_dma("restart");
        show_and_check("restart");
    endtask

    task automatic test_cpu_contention();
        load_table();
        compute_expected();
        @(posedge clk);
        cpu_addr <= base_word + 17'd9;
        cpu_rd   <= 1'b1;
        pulse_dma_ok();
        // CPU keeps the bus so the DMA has to wait
        for (int i = 0; i < 200; i++) begin
            @(negedge clk);
            compare("cpu_contention busreq", 32'd1, 32'(busreq));
        end
        compare("cpu_contention mem_addr", 32'(base_word + 17'd9), 32'(mem_addr));
        compare("cpu_contention cpu_ok", 32'd1, 32'(cpu_ok));
        compare("cpu_contention cpu_data", 32'(vram_img[9]), 32'(cpu_data));
        @(posedge clk);
        cpu_rd <= 1'b0;
        finish_dma("cpu_contention");
        show_and_check("cpu_contention");
        cpu_read("cpu_read 5", 5);
        cpu_read("cpu_read 600", 600);
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        pxl_cen    = 1'b0;
        obj_dma_ok = 1'b0;
        vram_base  = base_reg;
        cpu_rd     = 1'b0;
        cpu_addr   = '0;
        table_addr = '0;
        lat        = 3'd1;
        lat_state  = 32'h95ef_d662;
        data_state = 32'h95ef_d662;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        test_full_copy();
        test_end_marker();
        test_double_buffer();
        test_restart();
        test_cpu_contention();
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/vram_model.sv ====
// behavioral VRAM for the testbench, answers a stable address after a variable latency
`timescale 1ns/100ps
`default_nettype none

module vram_model import obj_pkg::*; #(
    parameter int lat_max = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [2:0] lat,
    input  vram_addr_t addr,
    output vram_word_t data,
    output logic       ok
);

    vram_word_t mem [0:131071];
    vram_addr_t cur;
    logic [2:0] cnt;
    logic       ready;

    // background pattern mixes every address bit
    initial begin
        for (int a = 0; a < 131072; a++) begin
            mem[a] = 16'(a) ^ 16'(a >> 5);
        end
    end

    // backdoor write used by the testbench
    task automatic load_word(input vram_addr_t a, input vram_word_t d);
        mem[a] = d;
    endtask

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cur   <= '0;
            cnt   <= 3'd1;
            ready <= 1'b0;
            data  <= '0;
        end else if (addr != cur) begin
            // new request, restart the latency count
            cur   <= addr;
            cnt   <= (lat > 3'(lat_max)) ? 3'(lat_max) : lat;
            ready <= 1'b0;
        end else if (cnt > 3'd1) begin
            cnt <= cnt - 3'd1;
        end else begin
            ready <= 1'b1;
            data  <= mem[cur];
        end
    end

    // valid drops at once when the address moves
    assign ok = ready && (addr == cur);

endmodule

`default_nettype wire

// ==== verilog.f ====
verilog/obj_pkg.sv
verilog/obj_table_dma.sv
verilog/obj_table_ram.sv
verilog/vram_arbiter.sv
verilog/obj_dma_sys.sv
dv/vram_model.sv
dv/obj_dma_tb.sv

// ==== verilog/obj_dma_sys.sv ====
// object table subsystem top, joins the DMA, the table buffer and the VRAM arbiter
`timescale 1ns/100ps
`default_nettype none

module obj_dma_sys import obj_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        pxl_cen,
    input  logic        obj_dma_ok,
    input  vram_base_t  vram_base,
    input  logic        cpu_rd,
    input  vram_addr_t  cpu_addr,
    input  vram_word_t  mem_data,
    input  logic        mem_ok,
    input  table_addr_t table_addr,
    output vram_addr_t  mem_addr,
    output vram_word_t  cpu_data,
    output logic        cpu_ok,
    output vram_word_t  table_data,
    output logic        busreq
);

    // DMA to arbiter
    vram_addr_t  dma_addr;
    logic        busack;
    vram_word_t  vram_data;
    logic        vram_ok;

    // DMA to buffer
    logic        wr_en;
    logic [10:0] wr_addr;
    vram_word_t  wr_data;
    logic        buf_sel;
    logic        rd_sel;

    // renderer always reads the half not being written
    assign rd_sel = ~buf_sel;

    obj_table_dma obj_table_dma_inst (
        .clk        (clk),
        .rst        (rst),
        .pxl_cen    (pxl_cen),
        .obj_dma_ok (obj_dma_ok),
        .vram_base  (vram_base),
        .busack     (busack),
        .vram_data  (vram_data),
        .vram_ok    (vram_ok),
        .busreq     (busreq),
        .dma_addr   (dma_addr),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .buf_sel    (buf_sel)
    );

    obj_table_ram obj_table_ram_inst (
        .clk        (clk),
        .rst        (rst),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .rd_sel     (rd_sel),
        .table_addr (table_addr),
        .table_data (table_data)
    );

    vram_arbiter vram_arbiter_inst (
        .clk        (clk),
        .rst        (rst),
        .busreq     (busreq),
        .dma_addr   (dma_addr),
        .cpu_rd     (cpu_rd),
        .cpu_addr   (cpu_addr),
        .mem_data   (mem_data),
        .mem_ok     (mem_ok),
        .busack     (busack),
        .vram_data  (vram_data),
        .vram_ok    (vram_ok),
        .mem_addr   (mem_addr),
        .cpu_data   (cpu_data),
        .cpu_ok     (cpu_ok)
    );

endmodule

`default_nettype wire

// ==== verilog/obj_pkg.sv ====
// shared widths and DMA state encoding for the object table path, imported by every block
`default_nettype none

package obj_pkg;

    // one word of VRAM or of the object table
    typedef logic [15:0] vram_word_t;

    // VRAM word address
    // index 0 here is byte address bit 1
    typedef logic [16:0] vram_addr_t;

    // base register as written by the CPU
    // only bits 9 to 1 pick the table start
    typedef logic [15:0] vram_base_t;

    // entry index seen by the renderer, 1024 words per half
    typedef logic [9:0] table_addr_t;

    // DMA sequencer states
    typedef enum logic [1:0] {
        // waiting for the frame strobe
        dma_idle       = 2'd0,
        // one word per accepted VRAM read
        dma_copy       = 2'd1,
        // zeros up to the last entry
        dma_fill       = 2'd2,
        // cache clear cycle, then wait for the bus grant
        dma_grant_wait = 2'd3
    } dma_state_t;

    // attribute high byte that ends the object list
    localparam logic [7:0] end_marker = 8'hFF;

endpackage

`default_nettype wire

// ==== verilog/obj_table_dma.sv ====
// frame-triggered DMA that copies the object table from VRAM into the write half of the buffer
`timescale 1ns/100ps
`default_nettype none

module obj_table_dma import obj_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        pxl_cen,
    input  logic        obj_dma_ok,
    input  vram_base_t  vram_base,
    input  logic        busack,
    input  vram_word_t  vram_data,
    input  logic        vram_ok,
    output logic        busreq,
    output vram_addr_t  dma_addr,
    output logic        wr_en,
    output logic [10:0] wr_addr,
    output vram_word_t  wr_data,
    output logic        buf_sel
);

    dma_state_t  state;
    vram_addr_t  vram_cnt;
    table_addr_t idx;
    logic        wait_cycle;
    logic        restart;
    logic        take;
    logic        last;
    logic        is_end;
    logic [10:0] wr_phys;

    // counters run in natural order
    // low two bits flipped so each group is fetched attribute word first
    assign dma_addr = {vram_cnt[16:2], ~vram_cnt[1:0]};
    assign wr_phys  = {buf_sel, idx[9:2], ~idx[1:0]};

    // a word is taken on a pixel beat with the bus granted and valid data
    assign take = pxl_cen && busack && vram_ok && !wait_cycle;
    assign last = &idx;

    // end marker only counts on the first fetch of a group
    assign is_end = (vram_data[15:8] == end_marker) && (idx[1:0] == 2'b00);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // clear the write half right out of reset
            state      <= dma_fill;
            idx        <= '0;
            vram_cnt   <= '0;
            busreq     <= 1'b0;
            buf_sel    <= 1'b1;
            wait_cycle <= 1'b1;
            restart    <= 1'b0;
            wr_en      <= 1'b0;
            wr_addr    <= '0;
            wr_data    <= '0;
        end else begin
            wr_en <= 1'b0;
            if (obj_dma_ok && state != dma_idle) begin
                // new frame while busy
                // go back through idle, keep busreq as it is
                restart <= 1'b1;
                state   <= dma_idle;
            end else begin
                case (state)
                    dma_idle: begin
                        busreq     <= 1'b0;
                        wait_cycle <= 1'b1;
                        if (obj_dma_ok || restart) begin
                            vram_cnt <= {vram_base[9:1], 8'd0};
                            idx      <= '0;
                            busreq   <= 1'b1;
                            // swap halves, renderer gets the table just built
                            buf_sel  <= ~buf_sel;
                            restart  <= 1'b0;
                            state    <= dma_grant_wait;
                        end
                    end
                    dma_grant_wait: begin
                        // stays at least one cycle so the VRAM cache can drop old words
                        if (busack) begin
                            state <= dma_copy;
                        end
                    end
                    dma_copy: begin
                        if (pxl_cen) begin
                            // one beat skipped after each accepted word
                            wait_cycle <= 1'b0;
                            if (take) begin
                                if (is_end) begin
                                    busreq <= 1'b0;
                                    state  <= dma_fill;
                                end else begin
                                    wr_en      <= 1'b1;
                                    wr_addr    <= wr_phys;
                                    wr_data    <= vram_data;
                                    idx        <= idx + 10'd1;
                                    vram_cnt   <= vram_cnt + 17'd1;
                                    wait_cycle <= 1'b1;
                                    if (last) begin
                                        busreq <= 1'b0;
                                        state  <= dma_idle;
                                    end
                                end
                            end
                        end
                    end
                    dma_fill: begin
                        // no bus needed, one zero word per clock
                        wr_en   <= 1'b1;
                        wr_addr <= wr_phys;
                        wr_data <= '0;
                        idx     <= idx + 10'd1;
                        if (last) begin
                            state <= dma_idle;
                        end
                    end
                    default: state <= dma_idle;
                endcase
            end
        end
    end

    // writes only start from copy or fill
    a_no_wr_from_idle: assert property (
        @(posedge clk) disable iff (rst)
        $rose(wr_en) |-> $past(state) != dma_idle
    );

    // bus is released once the zero fill begins
    a_fill_drops_bus: assert property (
        @(posedge clk) disable iff (rst)
        (state == dma_fill && $past(state) != dma_fill) |=> !busreq
    );

endmodule

`default_nettype wire

// ==== verilog/obj_table_ram.sv ====
// double-buffered object table, DMA writes one half while the renderer reads the other
`timescale 1ns/100ps
`default_nettype none

module obj_table_ram import obj_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        wr_en,
    input  logic [10:0] wr_addr,
    input  vram_word_t  wr_data,
    input  logic        rd_sel,
    input  table_addr_t table_addr,
    output vram_word_t  table_data
);

    // two halves of 1024 words
    // top address bit picks the half
    vram_word_t mem [0:2047];

    // DMA side, address already carries the half bit
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // renderer side
    // one cycle read latency
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            table_data <= '0;
        end else begin
            table_data <= mem[{rd_sel, table_addr}];
        end
    end

    // the half on display is never overwritten
    a_wr_other_half: assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> wr_addr[10] != rd_sel
    );

endmodule

`default_nettype wire

// ==== verilog/vram_arbiter.sv ====
// shares the VRAM read port between CPU and DMA and masks read-valid after address changes
`timescale 1ns/100ps
`default_nettype none

module vram_arbiter import obj_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       busreq,
    input  vram_addr_t dma_addr,
    input  logic       cpu_rd,
    input  vram_addr_t cpu_addr,
    input  vram_word_t mem_data,
    input  logic       mem_ok,
    output logic       busack,
    output vram_word_t vram_data,
    output logic       vram_ok,
    output vram_addr_t mem_addr,
    output vram_word_t cpu_data,
    output logic       cpu_ok
);

    vram_addr_t last_addr;
    logic       addr_chg;
    logic       addr_chg_q;
    logic       addr_ok;

    // DMA owns the port while granted
    assign mem_addr = busack ? dma_addr : cpu_addr;

    // address moved against the previous cycle
    assign addr_chg = mem_addr != last_addr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busack     <= 1'b0;
            last_addr  <= '0;
            // nothing valid straight out of reset
            addr_chg_q <= 1'b1;
        end else begin
            // grant waits for the CPU to finish its read
            // then sticks until the DMA lets go
            busack     <= busreq && (busack || !cpu_rd);
            last_addr  <= mem_addr;
            addr_chg_q <= addr_chg;
        end
    end

    // data from VRAM is only trusted once the address has been
    // stable for the change cycle and the one after it
    assign addr_ok = !addr_chg && !addr_chg_q;

    // same read data goes to both masters
    assign vram_data = mem_data;
    assign cpu_data  = mem_data;

    assign vram_ok = busack && mem_ok && addr_ok;

    // CPU sees nothing while the DMA holds the bus
    assign cpu_ok = !busack && cpu_rd && mem_ok && addr_ok;

    // grant only follows a request seen the cycle before
    a_grant_needs_req: assert property (
        @(posedge clk) disable iff (rst)
        busack |-> $past(busreq)
    );

endmodule

`default_nettype wire
